// ==== logic/rv_core_pkg.sv ====
// shared widths, opcodes and enums for the RV32I core
// loads, stores and system opcodes are decoded but never executed
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    // recognised for format only, they retire as no-ops
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no format, unknown opcode
    } inst_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    typedef enum logic {
        IDLE,  // address out, request pulse
        WAIT   // instruction word valid, execute and retire
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/fetch_ctrl.sv ====
// two-state fetch, one instruction every 2 cycles
// imem must return the word in the cycle right after imem_req
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               jump_en,
    input  wire rv_core_pkg::word_t jump_target,
    output rv_core_pkg::word_t      pc,
    output rv_core_pkg::word_t      snpc,
    output logic                    imem_req,
    output logic                    execute,
    output logic                    retire
);

    rv_core_pkg::fetch_state_t state;
    rv_core_pkg::fetch_state_t next_state;

    assign snpc    = pc + 32'd4;
    assign execute = (state == rv_core_pkg::WAIT);
    assign retire  = execute;  // every executed word retires

    always_comb begin
        case (state)
            rv_core_pkg::IDLE: next_state = imem_req ? rv_core_pkg::WAIT : rv_core_pkg::IDLE;
            rv_core_pkg::WAIT: next_state = rv_core_pkg::IDLE;
            default:           next_state = rv_core_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rv_core_pkg::IDLE;
            imem_req <= 1'b0;
            pc       <= rv_core_pkg::RESET_PC;
        end else begin
            state    <= next_state;
            imem_req <= (next_state == rv_core_pkg::IDLE);  // high for each IDLE cycle
            if (execute)
                pc <= jump_en ? jump_target : snpc;  // end of WAIT
        end
    end

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
// combinational RV32I decode, no state
// alu_op is ADD for every opcode outside OP and OP-IMM
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire rv_core_pkg::word_t inst,
    output logic [6:0]              opcode,
    output logic [2:0]              funct3,
    output rv_core_pkg::reg_addr_t  rd,
    output rv_core_pkg::reg_addr_t  rs1,
    output rv_core_pkg::reg_addr_t  rs2,
    output rv_core_pkg::word_t      imm,
    output rv_core_pkg::inst_t      inst_type,
    output rv_core_pkg::alu_op_t    alu_op
);

    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            rv_core_pkg::OPC_OP:     inst_type = rv_core_pkg::TYPE_R;
            rv_core_pkg::OPC_OP_IMM,
            rv_core_pkg::OPC_JALR,
            rv_core_pkg::OPC_LOAD,
            rv_core_pkg::OPC_SYSTEM: inst_type = rv_core_pkg::TYPE_I;
            rv_core_pkg::OPC_STORE:  inst_type = rv_core_pkg::TYPE_S;
            rv_core_pkg::OPC_BRANCH: inst_type = rv_core_pkg::TYPE_B;
            rv_core_pkg::OPC_LUI,
            rv_core_pkg::OPC_AUIPC:  inst_type = rv_core_pkg::TYPE_U;
            rv_core_pkg::OPC_JAL:    inst_type = rv_core_pkg::TYPE_J;
            default:                 inst_type = rv_core_pkg::TYPE_N;
        endcase
    end

    // sign-extended immediates per format
    always_comb begin
        case (inst_type)
            rv_core_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_core_pkg::TYPE_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_core_pkg::TYPE_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_core_pkg::TYPE_U: imm = {inst[31:12], 12'h000};
            rv_core_pkg::TYPE_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:             imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_core_pkg::ADD;
        if (opcode == rv_core_pkg::OPC_OP || opcode == rv_core_pkg::OPC_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // ADDI has no SUB form, imm bit 10 is just data there
                    if (opcode == rv_core_pkg::OPC_OP && funct7[5])
                        alu_op = rv_core_pkg::SUB;
                end
                3'b001:  alu_op = rv_core_pkg::SLL;
                3'b010:  alu_op = rv_core_pkg::SLT;
                3'b011:  alu_op = rv_core_pkg::SLTU;
                3'b100:  alu_op = rv_core_pkg::XOR;
                3'b101:  alu_op = funct7[5] ? rv_core_pkg::SRA : rv_core_pkg::SRL;
                3'b110:  alu_op = rv_core_pkg::OR;
                default: alu_op = rv_core_pkg::AND;  // 3'b111
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// 32 x 32 integer registers, two async reads and one write
// writes to x0 are dropped here, x0 always reads zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   we,
    input  wire rv_core_pkg::reg_addr_t waddr,
    input  wire rv_core_pkg::word_t     wdata,
    input  wire rv_core_pkg::reg_addr_t raddr1,
    input  wire rv_core_pkg::reg_addr_t raddr2,
    output rv_core_pkg::word_t          rdata1,
    output rv_core_pkg::word_t          rdata2
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
// ALU, branch compare, jump target and writeback select
// loads, stores, system and unknown opcodes write nothing and fall through
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic                 execute,
    input  wire logic [6:0]           opcode,
    input  wire logic [2:0]           funct3,
    input  wire rv_core_pkg::inst_t   inst_type,
    input  wire rv_core_pkg::alu_op_t alu_op,
    input  wire rv_core_pkg::word_t   imm,
    input  wire rv_core_pkg::word_t   pc,
    input  wire rv_core_pkg::word_t   snpc,
    input  wire rv_core_pkg::word_t   rs1_data,
    input  wire rv_core_pkg::word_t   rs2_data,
    output logic                      rd_we,
    output rv_core_pkg::word_t        rd_wdata,
    output logic                      jump_en,
    output rv_core_pkg::word_t        jump_target
);

    rv_core_pkg::word_t alu_a;
    rv_core_pkg::word_t alu_b;
    rv_core_pkg::word_t alu_result;
    logic [4:0]         shamt;
    logic               taken;
    logic               writes_rd;

    always_comb begin
        case (inst_type)
            rv_core_pkg::TYPE_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            rv_core_pkg::TYPE_U: begin
                alu_a = (opcode == rv_core_pkg::OPC_LUI) ? '0 : pc;
                alu_b = imm;
            end
            rv_core_pkg::TYPE_J,
            rv_core_pkg::TYPE_B: begin
                alu_a = pc;  // target = pc + offset
                alu_b = imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = imm;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            rv_core_pkg::SUB:  alu_result = alu_a - alu_b;
            rv_core_pkg::SLL:  alu_result = alu_a << shamt;
            rv_core_pkg::SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_core_pkg::SLTU: alu_result = {31'b0, alu_a < alu_b};
            rv_core_pkg::XOR:  alu_result = alu_a ^ alu_b;
            rv_core_pkg::SRL:  alu_result = alu_a >> shamt;
            rv_core_pkg::SRA:  alu_result = rv_core_pkg::word_t'($signed(alu_a) >>> shamt);
            rv_core_pkg::OR:   alu_result = alu_a | alu_b;
            rv_core_pkg::AND:  alu_result = alu_a & alu_b;
            default:           alu_result = alu_a + alu_b;
        endcase
    end

    // compare always on the register operands
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        writes_rd   = 1'b0;
        rd_wdata    = alu_result;
        case (inst_type)
            rv_core_pkg::TYPE_R,
            rv_core_pkg::TYPE_U: writes_rd = 1'b1;
            rv_core_pkg::TYPE_I: begin
                if (opcode == rv_core_pkg::OPC_JALR) begin
                    jump_en     = 1'b1;
                    jump_target = {alu_result[31:1], 1'b0};
                    writes_rd   = 1'b1;
                    rd_wdata    = snpc;  // link address
                end else if (opcode == rv_core_pkg::OPC_OP_IMM) begin
                    writes_rd = 1'b1;
                end
            end
            rv_core_pkg::TYPE_J: begin
                jump_en   = 1'b1;
                writes_rd = 1'b1;
                rd_wdata  = snpc;
            end
            rv_core_pkg::TYPE_B: jump_en = taken;
            default: ;  // store and unknown, pc+4 only
        endcase
    end

    assign rd_we = execute && writes_rd;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
// RV32I integer core without loads, stores or CSRs
// imem has one cycle latency and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire rv_core_pkg::word_t imem_data,
    output logic                    imem_req,
    output rv_core_pkg::word_t      imem_addr,
    output logic                    retire,
    output rv_core_pkg::word_t      retire_pc,
    output logic                    rd_we,
    output rv_core_pkg::reg_addr_t  rd_addr,
    output rv_core_pkg::word_t      rd_wdata
);

    rv_core_pkg::word_t     pc;
    rv_core_pkg::word_t     snpc;
    rv_core_pkg::word_t     jump_target;
    logic                   jump_en;
    logic                   execute;
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::word_t     imm;
    rv_core_pkg::inst_t     inst_type;
    rv_core_pkg::alu_op_t   alu_op;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;

    assign imem_addr = pc;  // held through IDLE and WAIT
    assign retire_pc = pc;

    fetch_ctrl u_fetch (
        .clk(clk), .reset(reset), .jump_en(jump_en), .jump_target(jump_target),
        .pc(pc), .snpc(snpc), .imem_req(imem_req), .execute(execute), .retire(retire)
    );

    inst_decoder u_dec (
        .inst(imem_data), .opcode(opcode), .funct3(funct3), .rd(rd_addr), .rs1(rs1),
        .rs2(rs2), .imm(imm), .inst_type(inst_type), .alu_op(alu_op)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset), .we(rd_we), .waddr(rd_addr), .wdata(rd_wdata),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    exec_unit u_exec (
        .execute(execute), .opcode(opcode), .funct3(funct3), .inst_type(inst_type),
        .alu_op(alu_op), .imm(imm), .pc(pc), .snpc(snpc), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .rd_we(rd_we), .rd_wdata(rd_wdata), .jump_en(jump_en),
        .jump_target(jump_target)
    );

endmodule

`default_nettype wire

// ==== bench/rv_core_assert.sv ====
// fetch FSM checks, bound into fetch_ctrl
// assumes one cycle memory latency and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               imem_req,
    input wire logic               retire,
    input wire rv_core_pkg::word_t pc
);

    int unsigned fail_count = 0;

    req_retire_apart: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && retire))
        else begin
            $error("imem_req and retire high in the same cycle");
            fail_count++;
        end

    // WAIT is entered only from a requesting IDLE
    retire_after_req: assert property (@(posedge clk) disable iff (reset)
        retire |-> $past(imem_req))
        else begin
            $error("retire without imem_req in the cycle before");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else begin
            $error("pc lost word alignment");
            fail_count++;
        end

endmodule

bind fetch_ctrl rv_core_assert u_assert (
    .clk(clk), .reset(reset), .imem_req(imem_req), .retire(retire), .pc(pc)
);

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
// runs the program and retire records of bench/program_trace.txt, start from the project root
// memory model answers in the cycle after imem_req, a fetch from an unloaded address fails
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int RETIRE_TIMEOUT = 8;  // cycles, one instruction needs 2

    logic                   clk;
    logic                   reset;
    rv_core_pkg::word_t     imem_data;
    logic                   imem_req;
    rv_core_pkg::word_t     imem_addr;
    logic                   retire;
    rv_core_pkg::word_t     retire_pc;
    logic                   rd_we;
    rv_core_pkg::reg_addr_t rd_addr;
    rv_core_pkg::word_t     rd_wdata;

    rv_core_pkg::word_t     mem [rv_core_pkg::word_t];  // sparse program image
    rv_core_pkg::word_t     exp_pc[$];
    logic                   exp_we[$];
    rv_core_pkg::reg_addr_t exp_rd[$];
    rv_core_pkg::word_t     exp_data[$];

    rv_core dut (
        .clk(clk), .reset(reset), .imem_data(imem_data), .imem_req(imem_req),
        .imem_addr(imem_addr), .retire(retire), .retire_pc(retire_pc), .rd_we(rd_we),
        .rd_addr(rd_addr), .rd_wdata(rd_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input rv_core_pkg::word_t exp,
                              input rv_core_pkg::word_t act);
        if (act !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s expected %h, got %h",
                                      $time, name, exp, act));
    endtask

    task automatic check_reg(input string name, input rv_core_pkg::reg_addr_t exp,
                             input rv_core_pkg::reg_addr_t act);
        if (act !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s expected x%0d, got x%0d",
                                      $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s expected %b, got %b",
                                      $time, name, exp, act));
    endtask

    // m lines fill the memory, r lines queue the expected retires
    task automatic load_trace();
        int                     fd;
        int                     n;
        string                  line;
        rv_core_pkg::word_t     addr;
        rv_core_pkg::word_t     value;
        logic                   we;
        rv_core_pkg::reg_addr_t rd;
        fd = $fopen("bench/program_trace.txt", "r");
        if (fd == 0)
            stop_on_failure("cannot open bench/program_trace.txt for reading");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line[0] == "#")
                continue;  // blank or comment
            if ($sscanf(line, "m %h %h", addr, value) == 2) begin
                mem[addr] = value;
            end else if ($sscanf(line, "r %h %h %h %h", addr, we, rd, value) == 4) begin
                exp_pc.push_back(addr);
                exp_we.push_back(we);
                exp_rd.push_back(rd);
                exp_data.push_back(value);
            end else begin
                stop_on_failure({"trace file holds a line that cannot be read: ", line});
            end
        end
        $fclose(fd);
    endtask

    // polls at falling edges, outputs are settled there
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire && cycles < RETIRE_TIMEOUT);
        if (!retire)
            stop_on_failure("no instruction retired within the timeout");
    endtask

    // word goes out while imem_req is up and stays for the whole WAIT cycle
    always @(negedge clk) begin
        if (!reset && imem_req) begin
            if (mem.exists(imem_addr))
                imem_data = mem[imem_addr];
            else
                stop_on_failure($sformatf("fetch from address %h, which holds no program word",
                                          imem_addr));
        end
    end

    // fetch FSM assertion failures end the run right away
    always @(negedge clk) begin
        if (dut.u_fetch.u_assert.fail_count != 0)
            stop_on_failure("a concurrent assertion on the fetch FSM failed");
    end

    initial begin
        reset     = 1'b1;
        imem_data = '0;
        load_trace();
        if (exp_pc.size() == 0)
            stop_on_failure("trace file holds no retire records");
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (exp_pc[i]) begin
            wait_retire();
            check_word("retire_pc", exp_pc[i], retire_pc);
            check_bit("rd_we", exp_we[i], rd_we);
            if (exp_we[i]) begin  // rd fields mean nothing without a write
                check_reg("rd_addr", exp_rd[i], rd_addr);
                check_word("rd_wdata", exp_data[i], rd_wdata);
            end
        end

        if (dut.u_fetch.u_assert.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_failure("a concurrent assertion on the fetch FSM failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== bench/program_trace.txt ====
# m <addr> <word>                        instruction memory, hex
# r <pc> <rd_we> <rd_addr> <rd_wdata>    expected retires in order, rd fields unused when rd_we is 0
m 80000000 ffb00093
m 80000004 00300113
m 80000008 401101b3
m 8000000c 4020d233
m 80000010 0020d2b3
m 80000014 0020a333
m 80000018 0020b3b3
m 8000001c 00710013
m 80000020 00200433
m 80000024 123454b7
m 80000028 00001517
m 8000002c 00208463
m 80000030 00209463
m 80000038 0020c463
m 80000040 0020e463
m 80000044 0020d463
m 80000048 0020f463
m 80000050 00c005ef
m 8000005c 01158667
m 80000064 00002683
m 80000068 0000058b
m 8000006c 0000006f
r 80000000 1 01 fffffffb  addi x1, x0, -5
r 80000004 1 02 00000003  addi x2, x0, 3
r 80000008 1 03 00000008  sub x3, x2, x1
r 8000000c 1 04 ffffffff  sra x4, x1, x2
r 80000010 1 05 1fffffff  srl x5, x1, x2
r 80000014 1 06 00000001  slt x6, x1, x2
r 80000018 1 07 00000000  sltu x7, x1, x2
r 8000001c 1 00 0000000a  addi x0, x2, 7
r 80000020 1 08 00000003  add x8, x0, x2
r 80000024 1 09 12345000  lui x9, 0x12345
r 80000028 1 0a 80001028  auipc x10, 0x1
r 8000002c 0 00 00000000  beq not taken
r 80000030 0 00 00000000  bne taken
r 80000038 0 00 00000000  blt taken
r 80000040 0 00 00000000  bltu not taken
r 80000044 0 00 00000000  bge not taken
r 80000048 0 00 00000000  bgeu taken
r 80000050 1 0b 80000054  jal x11, +12
r 8000005c 1 0c 80000060  jalr x12, 17(x11)
r 80000064 0 00 00000000  lw, dropped
r 80000068 0 00 00000000  custom-0 opcode
r 8000006c 1 00 80000070  jal x0, 0
r 8000006c 1 00 80000070  loops on itself

// ==== sources.f ====
logic/rv_core_pkg.sv
logic/fetch_ctrl.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/fetch_ctrl.sv
  - logic/inst_decoder.sv
  - logic/reg_file.sv
  - logic/exec_unit.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - bench/rv_core_assert.sv
      - bench/rv_core_tb.sv
